/* mem_types_pkg.sv */
package mem_types_pkg;

	// Memory operation carried down from decode
	typedef enum logic [3:0] {
		OP_NONE,
		OP_LB,
		OP_LBU,
		OP_LH,
		OP_LHU,
		OP_LW,
		OP_LWL,
		OP_LWR,
		OP_SB,
		OP_SH,
		OP_SW,
		OP_SWL,
		OP_SWR
	} mem_op_e;

	typedef struct packed {
		mem_op_e mem_op;
		logic    regwrite;
		logic    mfc0;
		logic    mtc0;
		logic    eret;
		logic    reserved_instr;
		logic    in_delay_slot;
	} ex_ctrl_t;

	// EX/MEM record
	typedef struct packed {
		ex_ctrl_t    ctrl;
		logic [31:0] pc;
		logic [31:0] ex_out;
		logic [31:0] rtdata;
		logic [4:0]  rd;
		logic [4:0]  reg_waddr;
		logic        intovf;
	} etom_t;

	// MEM/WB record
	typedef struct packed {
		logic [31:0] result;
		logic [4:0]  reg_waddr;
		logic        regwrite;
		logic        exc;
		logic        redirect;
		logic [31:0] redirect_addr;
	} mtow_t;

endpackage

/* mem_arch_pkg.sv */
package mem_arch_pkg;

	// Cause.ExcCode values
	localparam logic [4:0] EXC_ADEL = 5'd4;
	localparam logic [4:0] EXC_ADES = 5'd5;
	localparam logic [4:0] EXC_RI   = 5'd10;
	localparam logic [4:0] EXC_OV   = 5'd12;

	// CP0 register numbers for select 0
	localparam logic [4:0] CP0_BADVADDR = 5'd8;
	localparam logic [4:0] CP0_STATUS   = 5'd12;
	localparam logic [4:0] CP0_CAUSE    = 5'd13;
	localparam logic [4:0] CP0_EPC      = 5'd14;

	// General exception entry with BEV set
	localparam logic [31:0] EXC_VECTOR = 32'hBFC0_0380;

	// Data RAM geometry
	localparam int RAM_WORDS = 256;
	localparam int RAM_AW    = 8;

endpackage

/* mem_bus_if.sv */
`timescale 1ns/1ps

interface mem_bus_if;
	import mem_arch_pkg::*;

	logic              req;
	logic              wr;
	logic [3:0]        byte_en;
	logic [RAM_AW-1:0] word_addr;
	logic [31:0]       wdata;
	logic [31:0]       rdata;

	modport stage (
		output req, wr, byte_en, word_addr, wdata,
		input  rdata
	);

	modport ram (
		input  req, wr, byte_en, word_addr, wdata,
		output rdata
	);

endinterface

/* stage_reg.sv */
`timescale 1ns/1ps

module stage_reg #(
	parameter type payload_t = mem_types_pkg::etom_t
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	input  payload_t in_data,
	output logic     out_valid,
	output payload_t out_data
);

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= in_valid;
		end
	end

	always_ff @(posedge clk) begin
		out_data <= in_data;
	end

	assert property (@(posedge clk) rst |=> !out_valid);

endmodule

/* store_align.sv */
`timescale 1ns/1ps

module store_align (
	input  mem_types_pkg::mem_op_e op,
	input  logic [31:0]            addr,
	input  logic [31:0]            rtdata,
	output logic [3:0]             byte_en,
	output logic [31:0]            wdata,
	output logic                   is_store,
	output logic                   is_load,
	output logic                   misaligned
);
	import mem_types_pkg::*;

	always_comb begin
		is_load  = op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW, OP_LWL, OP_LWR};
		is_store = op inside {OP_SB, OP_SH, OP_SW, OP_SWL, OP_SWR};

		// Unaligned forms never trap
		case (op)
			OP_LH, OP_LHU, OP_SH: misaligned = addr[0];
			OP_LW, OP_SW:         misaligned = |addr[1:0];
			default:              misaligned = 1'b0;
		endcase

		byte_en = 4'b0000;
		wdata   = rtdata;
		case (op)
			OP_SB: begin
				byte_en = 4'b0001 << addr[1:0];
				wdata   = {4{rtdata[7:0]}};
			end
			OP_SH: begin
				byte_en = addr[1] ? 4'b1100 : 4'b0011;
				wdata   = {2{rtdata[15:0]}};
			end
			OP_SW: begin
				byte_en = 4'b1111;
			end
			// Top bytes of rt land in bytes 0..k
			OP_SWL: begin
				byte_en = 4'b1111 >> (~addr[1:0]);
				wdata   = rtdata >> {~addr[1:0], 3'b000};
			end
			// Low bytes of rt land in bytes k..3
			OP_SWR: begin
				byte_en = 4'b1111 << addr[1:0];
				wdata   = rtdata << {addr[1:0], 3'b000};
			end
			default: begin
				byte_en = 4'b0000;
			end
		endcase

		assert (!(is_store && !misaligned) || byte_en != 4'b0000);
	end

endmodule

/* load_extend.sv */
`timescale 1ns/1ps

module load_extend (
	input  mem_types_pkg::mem_op_e op,
	input  logic [1:0]             offset,
	input  logic [31:0]            rdata,
	input  logic [31:0]            rtdata,
	output logic [31:0]            result
);
	import mem_types_pkg::*;

	logic [7:0]  sel_byte;
	logic [15:0] sel_half;
	logic [31:0] lwl_word;
	logic [31:0] lwr_word;

	assign sel_byte = rdata[{offset, 3'b000} +: 8];
	assign sel_half = offset[1] ? rdata[31:16] : rdata[15:0];

	// Memory bytes 0..k go to the top of rt
	always_comb begin
		case (offset)
			2'd0:    lwl_word = {rdata[7:0], rtdata[23:0]};
			2'd1:    lwl_word = {rdata[15:0], rtdata[15:0]};
			2'd2:    lwl_word = {rdata[23:0], rtdata[7:0]};
			default: lwl_word = rdata;
		endcase
	end

	// Memory bytes k..3 go to the bottom of rt
	always_comb begin
		case (offset)
			2'd0:    lwr_word = rdata;
			2'd1:    lwr_word = {rtdata[31:24], rdata[31:8]};
			2'd2:    lwr_word = {rtdata[31:16], rdata[31:16]};
			default: lwr_word = {rtdata[31:8], rdata[31:24]};
		endcase
	end

	always_comb begin
		case (op)
			OP_LB:   result = {{24{sel_byte[7]}}, sel_byte};
			OP_LBU:  result = {24'b0, sel_byte};
			OP_LH:   result = {{16{sel_half[15]}}, sel_half};
			OP_LHU:  result = {16'b0, sel_half};
			OP_LW:   result = rdata;
			OP_LWL:  result = lwl_word;
			OP_LWR:  result = lwr_word;
			default: result = rdata;
		endcase
	end

endmodule

/* exc_cp0.sv */
`timescale 1ns/1ps

module exc_cp0 (
	input  logic        clk,
	input  logic        rst,
	input  logic        valid,
	input  logic [31:0] pc,
	input  logic        in_delay_slot,
	input  logic        reserved_instr,
	input  logic        intovf,
	input  logic        misaligned,
	input  logic        is_store,
	input  logic [31:0] badaddr,
	input  logic        mfc0,
	input  logic        mtc0,
	input  logic        eret,
	input  logic [4:0]  cp0_reg,
	input  logic [31:0] wdata,
	output logic        take_exc,
	output logic        redirect,
	output logic [31:0] redirect_addr,
	output logic [31:0] rdata
);
	import mem_arch_pkg::*;

	logic        status_exl;
	logic        cause_bd;
	logic [4:0]  cause_exc;
	logic [31:0] epc;
	logic [31:0] badvaddr;
	logic        addr_err;
	logic [4:0]  exc_code;

	// Address error only wins when nothing above it fires
	assign addr_err = misaligned & ~reserved_instr & ~intovf;
	assign take_exc = valid & (reserved_instr | intovf | misaligned);

	always_comb begin
		if (reserved_instr) begin
			exc_code = EXC_RI;
		end else if (intovf) begin
			exc_code = EXC_OV;
		end else if (is_store) begin
			exc_code = EXC_ADES;
		end else begin
			exc_code = EXC_ADEL;
		end
	end

	assign redirect      = take_exc | (valid & eret);
	assign redirect_addr = take_exc ? EXC_VECTOR : epc;

	always_ff @(posedge clk) begin
		if (rst) begin
			status_exl <= 1'b0;
			cause_bd   <= 1'b0;
			cause_exc  <= 5'd0;
		end else if (take_exc) begin
			status_exl <= 1'b1;
			cause_bd   <= in_delay_slot;
			cause_exc  <= exc_code;
		end else if (valid && eret) begin
			status_exl <= 1'b0;
		end else if (valid && mtc0 && cp0_reg == CP0_STATUS) begin
			status_exl <= wdata[1];
		end
	end

	always_ff @(posedge clk) begin
		if (take_exc) begin
			// Nested exception keeps the first return address
			if (!status_exl) begin
				epc <= in_delay_slot ? pc - 32'd4 : pc;
			end
			if (addr_err) begin
				badvaddr <= badaddr;
			end
		end else if (valid && mtc0) begin
			case (cp0_reg)
				CP0_EPC:      epc <= wdata;
				CP0_BADVADDR: badvaddr <= wdata;
				default:      ;
			endcase
		end
	end

	always_comb begin
		rdata = 32'd0;
		if (mfc0) begin
			case (cp0_reg)
				CP0_BADVADDR: rdata = badvaddr;
				CP0_STATUS:   rdata = {30'd0, status_exl, 1'b0};
				CP0_CAUSE:    rdata = {cause_bd, 24'd0, cause_exc, 2'b00};
				CP0_EPC:      rdata = epc;
				default:      rdata = 32'd0;
			endcase
		end
	end

	assert property (@(posedge clk) disable iff (rst) !valid |-> !take_exc && !redirect);

endmodule

/* data_ram.sv */
`timescale 1ns/1ps

module data_ram (
	input logic   clk,
	mem_bus_if.ram bus
);
	import mem_arch_pkg::*;

	logic [31:0] mem [RAM_WORDS];

	// Byte lanes written independently
	always_ff @(posedge clk) begin
		if (bus.req && bus.wr) begin
			for (int i = 0; i < 4; i++) begin
				if (bus.byte_en[i]) begin
					mem[bus.word_addr][8*i +: 8] <= bus.wdata[8*i +: 8];
				end
			end
		end
	end

	// Same-cycle read
	assign bus.rdata = mem[bus.word_addr];

	assert property (@(posedge clk) bus.req && bus.wr |-> bus.byte_en != 4'b0000);

endmodule

/* mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input  logic                 valid,
	input  mem_types_pkg::etom_t etom,
	mem_bus_if.stage             bus,
	output mem_types_pkg::mtow_t out_data,
	input  logic                 clk,
	input  logic                 rst
);
	import mem_types_pkg::*;
	import mem_arch_pkg::*;

	logic [3:0]  byte_en;
	logic [31:0] st_wdata;
	logic        is_store;
	logic        is_load;
	logic        misaligned;
	logic [31:0] load_result;
	logic        take_exc;
	logic        redirect;
	logic [31:0] redirect_addr;
	logic [31:0] cp0_rdata;

	store_align u_store_align (
		.op        (etom.ctrl.mem_op),
		.addr      (etom.ex_out),
		.rtdata    (etom.rtdata),
		.byte_en   (byte_en),
		.wdata     (st_wdata),
		.is_store  (is_store),
		.is_load   (is_load),
		.misaligned(misaligned)
	);

	load_extend u_load_extend (
		.op    (etom.ctrl.mem_op),
		.offset(etom.ex_out[1:0]),
		.rdata (bus.rdata),
		.rtdata(etom.rtdata),
		.result(load_result)
	);

	exc_cp0 u_exc_cp0 (
		.clk           (clk),
		.rst           (rst),
		.valid         (valid),
		.pc            (etom.pc),
		.in_delay_slot (etom.ctrl.in_delay_slot),
		.reserved_instr(etom.ctrl.reserved_instr),
		.intovf        (etom.intovf),
		.misaligned    (misaligned),
		.is_store      (is_store),
		.badaddr       (etom.ex_out),
		.mfc0          (etom.ctrl.mfc0),
		.mtc0          (etom.ctrl.mtc0),
		.eret          (etom.ctrl.eret),
		.cp0_reg       (etom.rd),
		.wdata         (etom.rtdata),
		.take_exc      (take_exc),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.rdata         (cp0_rdata)
	);

	// No RAM access for a faulting instruction
	assign bus.req       = valid & (is_load | is_store) & ~take_exc;
	assign bus.wr        = is_store;
	assign bus.byte_en   = byte_en;
	assign bus.word_addr = etom.ex_out[RAM_AW+1:2];
	assign bus.wdata     = st_wdata;

	always_comb begin
		if (is_load) begin
			out_data.result = load_result;
		end else if (etom.ctrl.mfc0) begin
			out_data.result = cp0_rdata;
		end else begin
			out_data.result = etom.ex_out;
		end
	end

	assign out_data.reg_waddr     = etom.reg_waddr;
	assign out_data.regwrite      = valid & etom.ctrl.regwrite & ~take_exc;
	assign out_data.exc           = take_exc;
	assign out_data.redirect      = redirect;
	assign out_data.redirect_addr = redirect_addr;

endmodule

/* mem_subsys_top.sv */
`timescale 1ns/1ps

module mem_subsys_top (
	input  logic        clk,
	input  logic        rst,
	input  logic        in_valid,
	input  logic [3:0]  in_op,
	input  logic [31:0] in_pc,
	input  logic [31:0] in_addr,
	input  logic [31:0] in_rtdata,
	input  logic [4:0]  in_rd,
	input  logic [4:0]  in_reg_waddr,
	input  logic        in_regwrite,
	input  logic        in_mfc0,
	input  logic        in_mtc0,
	input  logic        in_eret,
	input  logic        in_reserved,
	input  logic        in_intovf,
	input  logic        in_delay_slot,
	output logic        wb_valid,
	output logic        wb_regwrite,
	output logic [4:0]  wb_reg_waddr,
	output logic [31:0] wb_result,
	output logic        wb_exc,
	output logic        wb_redirect,
	output logic [31:0] wb_redirect_addr
);
	import mem_types_pkg::*;

	etom_t in_rec;
	etom_t em_rec;
	logic  em_valid;
	mtow_t mw_next;
	mtow_t wb_rec;

	mem_bus_if u_bus ();

	assign in_rec.ctrl.mem_op         = mem_op_e'(in_op);
	assign in_rec.ctrl.regwrite       = in_regwrite;
	assign in_rec.ctrl.mfc0           = in_mfc0;
	assign in_rec.ctrl.mtc0           = in_mtc0;
	assign in_rec.ctrl.eret           = in_eret;
	assign in_rec.ctrl.reserved_instr = in_reserved;
	assign in_rec.ctrl.in_delay_slot  = in_delay_slot;
	assign in_rec.pc                  = in_pc;
	assign in_rec.ex_out              = in_addr;
	assign in_rec.rtdata              = in_rtdata;
	assign in_rec.rd                  = in_rd;
	assign in_rec.reg_waddr           = in_reg_waddr;
	assign in_rec.intovf              = in_intovf;

	stage_reg #(.payload_t(etom_t)) u_ex_mem (
		.clk      (clk),
		.rst      (rst),
		.in_valid (in_valid),
		.in_data  (in_rec),
		.out_valid(em_valid),
		.out_data (em_rec)
	);

	mem_stage u_mem_stage (
		.valid   (em_valid),
		.etom    (em_rec),
		.bus     (u_bus),
		.out_data(mw_next),
		.clk     (clk),
		.rst     (rst)
	);

	stage_reg #(.payload_t(mtow_t)) u_mem_wb (
		.clk      (clk),
		.rst      (rst),
		.in_valid (em_valid),
		.in_data  (mw_next),
		.out_valid(wb_valid),
		.out_data (wb_rec)
	);

	data_ram u_data_ram (
		.clk(clk),
		.bus(u_bus)
	);

	assign wb_regwrite      = wb_rec.regwrite;
	assign wb_reg_waddr     = wb_rec.reg_waddr;
	assign wb_result        = wb_rec.result;
	assign wb_exc           = wb_rec.exc;
	assign wb_redirect      = wb_rec.redirect;
	assign wb_redirect_addr = wb_rec.redirect_addr;

endmodule

/* tb_mem_subsys.sv */
`timescale 1ns/1ps

module tb_mem_subsys;
	import mem_types_pkg::*;
	import mem_arch_pkg::*;

	logic        clk;
	logic        rst;
	logic        in_valid;
	logic [3:0]  in_op;
	logic [31:0] in_pc;
	logic [31:0] in_addr;
	logic [31:0] in_rtdata;
	logic [4:0]  in_rd;
	logic [4:0]  in_reg_waddr;
	logic        in_regwrite;
	logic        in_mfc0;
	logic        in_mtc0;
	logic        in_eret;
	logic        in_reserved;
	logic        in_intovf;
	logic        in_delay_slot;
	logic        wb_valid;
	logic        wb_regwrite;
	logic [4:0]  wb_reg_waddr;
	logic [31:0] wb_result;
	logic        wb_exc;
	logic        wb_redirect;
	logic [31:0] wb_redirect_addr;

	int errors;
	int checks;

	// Byte-wide RAM image and CP0 register model
	logic [7:0]  model_mem [0:1023];
	logic        model_exl;
	logic        model_bd;
	logic [4:0]  model_code;
	logic [31:0] model_epc;
	logic [31:0] model_badvaddr;

	localparam logic [31:0] PC_BASE = 32'h0040_0100;

	mem_subsys_top u_dut (.*);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
		end
	endtask

	task automatic check_reg(input string name, input logic [4:0] got, input logic [4:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%02h, expected 0x%02h", name, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_op(input string name, input mem_op_e got, input mem_op_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got 0x%h (%s), expected 0x%h (%s)",
				name, got, got.name(), exp, exp.name());
		end
	endtask

	task automatic issue_instr(input mem_op_e op, input logic [31:0] pc, input logic [31:0] addr,
			input logic [31:0] rtdata, input logic [4:0] rd, input logic [4:0] waddr,
			input logic regwrite, input logic mfc0, input logic mtc0, input logic eret,
			input logic reserved, input logic intovf, input logic ds);
		@(posedge clk);
		in_valid      <= 1'b1;
		in_op         <= op;
		in_pc         <= pc;
		in_addr       <= addr;
		in_rtdata     <= rtdata;
		in_rd         <= rd;
		in_reg_waddr  <= waddr;
		in_regwrite   <= regwrite;
		in_mfc0       <= mfc0;
		in_mtc0       <= mtc0;
		in_eret       <= eret;
		in_reserved   <= reserved;
		in_intovf     <= intovf;
		in_delay_slot <= ds;
	endtask

	task automatic end_issue();
		@(posedge clk);
		in_valid <= 1'b0;
	endtask

	// Outputs sampled on the falling edge
	task automatic wait_wb(output int waited);
		int n;
		waited = 0;
		n = 0;
		while (waited == 0 && n < 20) begin
			@(negedge clk);
			n++;
			if (wb_valid) begin
				waited = n;
			end
		end
		if (waited == 0) begin
			errors++;
			$display("Timeout: no writeback seen within 20 cycles");
		end
	endtask

	task automatic run_instr(input mem_op_e op, input logic [31:0] pc, input logic [31:0] addr,
			input logic [31:0] rtdata, input logic [4:0] rd, input logic [4:0] waddr,
			input logic regwrite, input logic mfc0, input logic mtc0, input logic eret,
			input logic reserved, input logic intovf, input logic ds);
		int waited;
		issue_instr(op, pc, addr, rtdata, rd, waddr, regwrite, mfc0, mtc0, eret,
			reserved, intovf, ds);
		end_issue();
		wait_wb(waited);
		if (waited != 0 && waited != 2) begin
			errors++;
			$display("Latency wrong: writeback came %0d cycles after issue, expected 2", waited);
		end
	endtask

	task automatic model_store(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] data);
		int a;
		int k;
		int b;
		a = addr[9:0];
		k = addr[1:0];
		b = a - k;
		case (op)
			OP_SB: model_mem[a] = data[7:0];
			OP_SH: for (int i = 0; i < 2; i++) model_mem[a + i] = data[8*i +: 8];
			OP_SW: for (int i = 0; i < 4; i++) model_mem[b + i] = data[8*i +: 8];
			OP_SWL: for (int i = 0; i <= k; i++) model_mem[b + i] = data[8*(3-k+i) +: 8];
			OP_SWR: for (int i = k; i < 4; i++) model_mem[b + i] = data[8*(i-k) +: 8];
			default: ;
		endcase
	endtask

	function automatic logic [31:0] model_load(input mem_op_e op, input logic [31:0] addr,
			input logic [31:0] rt);
		int a;
		int k;
		int b;
		logic [7:0]  byte_val;
		logic [15:0] half_val;
		logic [31:0] r;
		a = addr[9:0];
		k = addr[1:0];
		b = a - k;
		byte_val = model_mem[a];
		half_val = {model_mem[(a + 1) % 1024], model_mem[a]};
		r = rt;
		case (op)
			OP_LB:  r = {{24{byte_val[7]}}, byte_val};
			OP_LBU: r = {24'h0, byte_val};
			OP_LH:  r = {{16{half_val[15]}}, half_val};
			OP_LHU: r = {16'h0, half_val};
			OP_LW:  for (int i = 0; i < 4; i++) r[8*i +: 8] = model_mem[b + i];
			OP_LWL: for (int i = 0; i <= k; i++) r[8*(3-k+i) +: 8] = model_mem[b + i];
			OP_LWR: for (int i = k; i < 4; i++) r[8*(i-k) +: 8] = model_mem[b + i];
			default: ;
		endcase
		return r;
	endfunction

	task automatic model_exception(input logic [4:0] code, input logic [31:0] pc,
			input logic ds, input logic [31:0] addr);
		if (!model_exl) begin
			model_epc = ds ? pc - 32'd4 : pc;
		end
		if (code == EXC_ADEL || code == EXC_ADES) begin
			model_badvaddr = addr;
		end
		model_code = code;
		model_bd   = ds;
		model_exl  = 1'b1;
	endtask

	function automatic logic [31:0] cp0_expect(input logic [4:0] regnum);
		case (regnum)
			CP0_BADVADDR: return model_badvaddr;
			CP0_STATUS:   return {30'd0, model_exl, 1'b0};
			CP0_CAUSE:    return {model_bd, 24'd0, model_code, 2'b00};
			CP0_EPC:      return model_epc;
			default:      return 32'd0;
		endcase
	endfunction

	task automatic do_store(input mem_op_e op, input logic [31:0] addr, input logic [31:0] data);
		run_instr(op, PC_BASE, addr, data, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		check_flag($sformatf("wb_exc %s @0x%0h", op.name(), addr), wb_exc, 1'b0);
		model_store(op, addr, data);
	endtask

	task automatic do_load(input mem_op_e op, input logic [31:0] addr, input logic [31:0] rt);
		logic [4:0] waddr;
		waddr = 5'($urandom_range(1, 31));
		run_instr(op, PC_BASE, addr, rt, 5'd0, waddr, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0);
		check_word($sformatf("wb_result %s @0x%0h", op.name(), addr), wb_result,
			model_load(op, addr, rt));
		check_reg("wb_reg_waddr", wb_reg_waddr, waddr);
		check_flag("wb_regwrite", wb_regwrite, 1'b1);
		check_flag("wb_exc", wb_exc, 1'b0);
	endtask

	task automatic check_cp0(input logic [4:0] regnum, input string name);
		run_instr(OP_NONE, PC_BASE, 32'd0, 32'd0, regnum, 5'd2, 1'b1, 1'b1, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0);
		check_word({"wb_result MFC0 ", name}, wb_result, cp0_expect(regnum));
	endtask

	task automatic write_cp0(input logic [4:0] regnum, input logic [31:0] data);
		run_instr(OP_NONE, PC_BASE, 32'd0, data, regnum, 5'd0, 1'b0, 1'b0, 1'b1, 1'b0,
			1'b0, 1'b0, 1'b0);
		case (regnum)
			CP0_STATUS:   model_exl = data[1];
			CP0_EPC:      model_epc = data;
			CP0_BADVADDR: model_badvaddr = data;
			default:      ;
		endcase
	endtask

	task automatic check_exc_wb(input string name);
		check_flag({name, " wb_exc"}, wb_exc, 1'b1);
		check_flag({name, " wb_redirect"}, wb_redirect, 1'b1);
		check_word({name, " wb_redirect_addr"}, wb_redirect_addr, EXC_VECTOR);
		check_flag({name, " wb_regwrite"}, wb_regwrite, 1'b0);
	endtask

	task automatic report_test(input string name, input int start);
		$display("test %-14s finished, %0d errors", name, errors - start);
	endtask

	task automatic test_aligned();
		int start;
		logic [31:0] addr;
		start = errors;
		for (int w = 0; w < 3; w++) begin
			do_store(OP_SW, 32'h100 + 4 * w, $urandom());
		end
		do_store(OP_SH, 32'h102, $urandom());
		do_store(OP_SH, 32'h104, $urandom());
		do_store(OP_SB, 32'h109, $urandom());
		do_store(OP_SB, 32'h10B, $urandom());
		for (int w = 0; w < 3; w++) begin
			addr = 32'h100 + 4 * w;
			do_load(OP_LW, addr, $urandom());
			for (int k = 0; k < 4; k += 2) begin
				do_load(OP_LH, addr + k, $urandom());
				do_load(OP_LHU, addr + k, $urandom());
			end
			for (int k = 0; k < 4; k++) begin
				do_load(OP_LB, addr + k, $urandom());
				do_load(OP_LBU, addr + k, $urandom());
			end
		end
		report_test("aligned", start);
	endtask

	task automatic test_unaligned();
		int start;
		start = errors;
		do_store(OP_SW, 32'h200, $urandom());
		do_store(OP_SW, 32'h204, $urandom());
		for (int k = 0; k < 4; k++) begin
			do_store(OP_SWL, 32'h200 + k, $urandom());
			do_load(OP_LW, 32'h200, $urandom());
			do_store(OP_SWR, 32'h204 + k, $urandom());
			do_load(OP_LW, 32'h204, $urandom());
		end
		for (int k = 0; k < 4; k++) begin
			do_load(OP_LWL, 32'h200 + k, $urandom());
			do_load(OP_LWR, 32'h204 + k, $urandom());
		end
		report_test("unaligned", start);
	endtask

	task automatic test_misaligned();
		int start;
		start = errors;
		write_cp0(CP0_STATUS, 32'd0);
		do_store(OP_SW, 32'h300, $urandom());
		run_instr(OP_LW, PC_BASE, 32'h302, 32'd0, 5'd0, 5'd9, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0);
		check_exc_wb("LW @0x302");
		model_exception(EXC_ADEL, PC_BASE, 1'b0, 32'h302);
		check_cp0(CP0_BADVADDR, "BadVAddr");
		check_cp0(CP0_CAUSE, "Cause");
		write_cp0(CP0_STATUS, 32'd0);
		run_instr(OP_SH, PC_BASE, 32'h301, $urandom(), 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0);
		check_exc_wb("SH @0x301");
		model_exception(EXC_ADES, PC_BASE, 1'b0, 32'h301);
		check_cp0(CP0_BADVADDR, "BadVAddr");
		check_cp0(CP0_CAUSE, "Cause");
		// RAM image was left alone, so the word must read back intact
		do_load(OP_LW, 32'h300, $urandom());
		write_cp0(CP0_STATUS, 32'd0);
		report_test("misaligned", start);
	endtask

	task automatic test_priority();
		int start;
		start = errors;
		run_instr(OP_LW, PC_BASE, 32'h303, 32'd0, 5'd0, 5'd3, 1'b1, 1'b0, 1'b0, 1'b0,
			1'b1, 1'b1, 1'b0);
		check_exc_wb("RI+OV+AdEL");
		model_exception(EXC_RI, PC_BASE, 1'b0, 32'h303);
		check_cp0(CP0_CAUSE, "Cause");
		write_cp0(CP0_STATUS, 32'd0);
		run_instr(OP_SW, PC_BASE, 32'h305, $urandom(), 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b1, 1'b0);
		check_exc_wb("OV+AdES");
		model_exception(EXC_OV, PC_BASE, 1'b0, 32'h305);
		check_cp0(CP0_CAUSE, "Cause");
		check_cp0(CP0_BADVADDR, "BadVAddr");
		write_cp0(CP0_STATUS, 32'd0);
		report_test("priority", start);
	endtask

	task automatic test_epc_exl();
		int start;
		start = errors;
		run_instr(OP_NONE, 32'h0040_1004, 32'd0, 32'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0,
			1'b1, 1'b0, 1'b1);
		check_exc_wb("RI in delay slot");
		model_exception(EXC_RI, 32'h0040_1004, 1'b1, 32'd0);
		check_cp0(CP0_EPC, "EPC");
		check_cp0(CP0_CAUSE, "Cause");
		check_cp0(CP0_STATUS, "Status");
		// Nested exception with EXL already set
		run_instr(OP_NONE, 32'h0040_2000, 32'h1234, 32'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b1, 1'b0);
		check_exc_wb("nested OV");
		model_exception(EXC_OV, 32'h0040_2000, 1'b0, 32'h1234);
		check_cp0(CP0_EPC, "EPC");
		check_cp0(CP0_CAUSE, "Cause");
		run_instr(OP_NONE, 32'h0040_2100, 32'd0, 32'd0, 5'd0, 5'd0, 1'b0, 1'b0, 1'b0, 1'b1,
			1'b0, 1'b0, 1'b0);
		check_flag("ERET wb_redirect", wb_redirect, 1'b1);
		check_flag("ERET wb_exc", wb_exc, 1'b0);
		check_word("ERET wb_redirect_addr", wb_redirect_addr, model_epc);
		model_exl = 1'b0;
		check_cp0(CP0_STATUS, "Status");
		report_test("epc_exl", start);
	endtask

	task automatic test_back_to_back();
		int start;
		int waited;
		logic [31:0] data;
		mem_op_e     op_by_waddr [32];
		mem_op_e     order_q [$];
		start = errors;
		data = $urandom();
		op_by_waddr[20] = OP_SW;
		op_by_waddr[21] = OP_LW;
		order_q.push_back(OP_SW);
		order_q.push_back(OP_LW);
		issue_instr(OP_SW, PC_BASE, 32'h380, data, 5'd0, 5'd20, 1'b0, 1'b0, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0);
		issue_instr(OP_LW, PC_BASE + 4, 32'h380, $urandom(), 5'd0, 5'd21, 1'b1, 1'b0, 1'b0,
			1'b0, 1'b0, 1'b0, 1'b0);
		end_issue();
		model_store(OP_SW, 32'h380, data);
		wait_wb(waited);
		if (waited != 0 && waited != 1) begin
			errors++;
			$display("Latency wrong: store writeback %0d cycles late", waited - 1);
		end
		check_op("first writeback op", op_by_waddr[wb_reg_waddr], order_q.pop_front());
		check_word("store wb_result", wb_result, 32'h380);
		check_flag("store wb_regwrite", wb_regwrite, 1'b0);
		@(negedge clk);
		check_flag("second wb_valid", wb_valid, 1'b1);
		check_op("second writeback op", op_by_waddr[wb_reg_waddr], order_q.pop_front());
		check_word("load wb_result", wb_result, model_load(OP_LW, 32'h380, 32'd0));
		check_flag("load wb_regwrite", wb_regwrite, 1'b1);
		@(negedge clk);
		check_flag("wb_valid after burst", wb_valid, 1'b0);
		report_test("back_to_back", start);
	endtask

	initial begin
		void'($urandom(32'h26e7_dbc1));
		errors         = 0;
		checks         = 0;
		rst            = 1'b1;
		in_valid       = 1'b0;
		in_op          = OP_NONE;
		in_pc          = 32'd0;
		in_addr        = 32'd0;
		in_rtdata      = 32'd0;
		in_rd          = 5'd0;
		in_reg_waddr   = 5'd0;
		in_regwrite    = 1'b0;
		in_mfc0        = 1'b0;
		in_mtc0        = 1'b0;
		in_eret        = 1'b0;
		in_reserved    = 1'b0;
		in_intovf      = 1'b0;
		in_delay_slot  = 1'b0;
		model_exl      = 1'b0;
		model_bd       = 1'b0;
		model_code     = 5'd0;
		model_epc      = 32'd0;
		model_badvaddr = 32'd0;
		repeat (8) @(posedge clk);
		rst <= 1'b0;

		test_aligned();
		test_unaligned();
		test_misaligned();
		test_priority();
		test_epc_exl();
		test_back_to_back();

		$display("Summary: 6 tests, %0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TEST RESULT: PASS");
		end else begin
			$display("TEST RESULT: FAIL");
		end
		$finish;
	end

endmodule

/* mem_subsys.f */
mem_types_pkg.sv
mem_arch_pkg.sv
mem_bus_if.sv
stage_reg.sv
store_align.sv
load_extend.sv
exc_cp0.sv
data_ram.sv
mem_stage.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
	--top-module tb_mem_subsys -f mem_subsys.f -o sim_mem_subsys
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/sim_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "TEST RESULT: PASS" "$LOG"; then
	echo "Simulation passed"
	exit 0
fi
echo "Simulation failed"
exit 1
